/* logic/mic_cfg_pkg.sv */
package mic_cfg_pkg;

  // Field widths of the sequencer
  localparam int UADDR_W     = 13;  // Control store address
  localparam int LC_W        = 8;   // Loop counter
  localparam int IR_W        = 7;   // Instruction vector latch
  localparam int RADDR_W     = 4;   // Register file address
  localparam int FLAG_W      = 8;   // Status flags to the condition mux

  // Return stack depth, the top level may override it
  localparam int STACK_DEPTH = 4;

  // Micro-address, wraps modulo 2^13
  typedef logic [UADDR_W-1:0] uaddr_t;

  typedef logic [LC_W-1:0]    lc_t;     // Loop count
  typedef logic [IR_W-1:0]    ir_t;     // Instruction vector
  typedef logic [RADDR_W-1:0] raddr_t;  // A or B register address

  // Literal field of the microword
  typedef logic [15:0]        csbit_t;

  typedef logic [15:0]        data_t;   // CD bus word
  typedef logic [FLAG_W-1:0]  flags_t;  // Indexed by tsel

endpackage

/* logic/mic_op_pkg.sv */
package mic_op_pkg;

  // Sequencing operation of the microword
  typedef enum logic [1:0] {
    SEQ_NEXT = 2'd0,  // Fall through to ma+1
    SEQ_JUMP = 2'd1,  // Conditional jump
    SEQ_CALL = 2'd2,  // Conditional call, pushes ma+1
    SEQ_RET  = 2'd3   // Conditional return
  } seq_op_t;

  // Source of the jump target low bits
  typedef enum logic [1:0] {
    JMP_LIT = 2'd0,  // All 13 bits from csbit
    JMP_VEC = 2'd1,  // Low nibble from IR[3:0]
    JMP_REG = 2'd2   // Low nibble from laa
  } jsel_t;

  // A register address source
  typedef enum logic [1:0] {
    ASEL_LIT = 2'd0,  // csbit[15:12]
    ASEL_PIL = 2'd1,  // Current priority level
    ASEL_IR  = 2'd2,  // IR[6:3]
    ASEL_LC  = 2'd3   // Loop counter low nibble
  } asel_t;

  // B register address source
  // IR fields are three bits wide and get a zero on top
  typedef enum logic [1:0] {
    BSEL_LIT  = 2'd0,  // csbit[11:8]
    BSEL_IRLO = 2'd1,  // IR[2:0]
    BSEL_IRHI = 2'd2,  // IR[5:3]
    BSEL_LC   = 2'd3
  } bsel_t;

endpackage

/* logic/mic_if.sv */
`timescale 1ns/100ps

// Results of the condition unit as seen by the rest of the sequencer
interface cond_if;
  import mic_cfg_pkg::*;

  logic   taken;   // Branch decision for the current microcycle
  logic   lcz;     // Loop counter is zero
  raddr_t lc_nib;  // Low nibble of the loop counter
  logic   cond_q;  // Condition as registered on the last step

  // Driven by the condition unit
  modport src (
    output taken,
    output lcz,
    output lc_nib,
    output cond_q
  );

  // Address selector only needs the decision
  modport seq (
    input taken
  );

  // Decode unit uses the counter as a register address source
  modport dec (
    input lc_nib
  );

endinterface

/* logic/mic_cond.sv */
`timescale 1ns/100ps

module mic_cond #(
  parameter int LC_W = mic_cfg_pkg::LC_W
) (
  input  logic                sysclk,
  input  logic                rst_n,
  input  logic                step,
  input  mic_cfg_pkg::flags_t flags,
  input  logic [2:0]          tsel,
  input  logic                tpol,
  input  logic                cond_en,
  input  logic                csloop,
  input  logic                ldlc,
  input  mic_cfg_pkg::data_t  cd,
  cond_if.src                 c
);
  import mic_cfg_pkg::*;

  logic [LC_W-1:0] lc;     // Loop counter
  logic            lc_nz;
  logic            flag_sel;
  logic            cond_ok;
  logic            cond_r;

  assign lc_nz    = |lc;
  assign flag_sel = flags[tsel] ^ tpol;  // tpol inverts the test

  // Loop test wins over the flag test
  always_comb begin
    if (csloop)
      cond_ok = lc_nz;
    else if (!cond_en)
      cond_ok = 1'b1;  // Unconditional
    else
      cond_ok = flag_sel;
  end

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      lc     <= '0;
      cond_r <= 1'b0;
    end else if (step) begin
      if (ldlc)
        lc <= cd[LC_W-1:0];
      else if (csloop && lc_nz)
        lc <= lc - 1'b1;  // Stops at zero
      cond_r <= cond_ok;
    end
  end

  assign c.taken  = cond_ok;
  assign c.lcz    = ~lc_nz;
  assign c.lc_nib = lc[RADDR_W-1:0];
  assign c.cond_q = cond_r;

  // A loop step on an empty counter must leave it at zero
  a_lc_no_wrap : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    (step && !ldlc && !lc_nz) |=> !lc_nz
  ) else $error("loop counter left zero without a load");

endmodule

/* logic/mic_decode.sv */
`timescale 1ns/100ps

module mic_decode (
  input  logic                sysclk,
  input  logic                rst_n,
  input  logic                step,
  input  logic                ldir,
  input  mic_cfg_pkg::data_t  cd,
  input  mic_cfg_pkg::csbit_t csbit,
  input  mic_cfg_pkg::raddr_t pil,
  input  mic_op_pkg::asel_t   asel,
  input  mic_op_pkg::bsel_t   bsel,
  input  mic_op_pkg::jsel_t   jsel,
  cond_if.dec                 c,
  output mic_cfg_pkg::raddr_t laa,
  output mic_cfg_pkg::raddr_t lba,
  output mic_cfg_pkg::uaddr_t target
);
  import mic_cfg_pkg::*;
  import mic_op_pkg::*;

  ir_t    ir;     // Instruction vector latch
  raddr_t laa_d;
  raddr_t lba_d;

  // A address mux, all sources seen before the step
  always_comb begin
    case (asel)
      ASEL_LIT: laa_d = csbit[15:12];
      ASEL_PIL: laa_d = pil;
      ASEL_IR:  laa_d = ir[IR_W-1:3];
      default:  laa_d = c.lc_nib;
    endcase
  end

  always_comb begin
    case (bsel)
      BSEL_LIT:  lba_d = csbit[11:8];
      BSEL_IRLO: lba_d = {1'b0, ir[2:0]};
      BSEL_IRHI: lba_d = {1'b0, ir[5:3]};
      default:   lba_d = c.lc_nib;
    endcase
  end

  // Upper target bits always come from the literal
  always_comb begin
    case (jsel)
      JMP_VEC: target = {csbit[UADDR_W-1:4], ir[3:0]};
      JMP_REG: target = {csbit[UADDR_W-1:4], laa};
      default: target = csbit[UADDR_W-1:0];
    endcase
  end

  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      ir  <= '0;
      laa <= '0;
      lba <= '0;
    end else if (step) begin
      if (ldir)
        ir <= cd[IR_W-1:0];
      laa <= laa_d;  // Reloaded every microcycle
      lba <= lba_d;
    end
  end

endmodule

/* logic/mic_stack.sv */
`timescale 1ns/100ps

module mic_stack #(
  parameter int STACK_DEPTH = mic_cfg_pkg::STACK_DEPTH
) (
  input  logic                sysclk,
  input  logic                rst_n,
  input  logic                push,
  input  logic                pop,
  input  mic_cfg_pkg::uaddr_t push_data,
  output mic_cfg_pkg::uaddr_t top,
  output logic                empty,
  output logic                full
);
  import mic_cfg_pkg::*;

  localparam int CNT_W = $clog2(STACK_DEPTH + 1);

  uaddr_t           stk [STACK_DEPTH];  // Entry 0 is the top
  logic [CNT_W-1:0] cnt;

  // Shift register stack, the bottom entry falls off on overflow
  always_ff @(posedge sysclk) begin
    if (push) begin
      stk[0] <= push_data;
      for (int i = 1; i < STACK_DEPTH; i++) begin
        stk[i] <= stk[i-1];
      end
    end else if (pop) begin
      for (int i = 0; i < STACK_DEPTH - 1; i++) begin
        stk[i] <= stk[i+1];
      end
    end
  end

  // Depth count, saturates when full
  always_ff @(posedge sysclk) begin
    if (!rst_n)
      cnt <= '0;
    else if (push && !full)
      cnt <= cnt + 1'b1;
    else if (pop && !empty)
      cnt <= cnt - 1'b1;
  end

  assign top   = stk[0];
  assign empty = (cnt == '0);
  assign full  = (cnt == CNT_W'(STACK_DEPTH));

  a_no_push_pop : assert property (
    @(posedge sysclk) disable iff (!rst_n)
    !(push && pop)
  ) else $error("stack push and pop in the same cycle");

endmodule

/* logic/mic_masel.sv */
`timescale 1ns/100ps

module mic_masel #(
  parameter int STACK_DEPTH = mic_cfg_pkg::STACK_DEPTH
) (
  input  logic                  sysclk,
  input  logic                  rst_n,
  input  logic                  step,
  input  mic_op_pkg::seq_op_t   seq_op,
  input  mic_cfg_pkg::uaddr_t   target,
  cond_if.seq                   c,
  output mic_cfg_pkg::uaddr_t   ma,
  output logic                  deep
);
  import mic_cfg_pkg::*;
  import mic_op_pkg::*;

  uaddr_t ma_inc;
  uaddr_t ma_d;
  uaddr_t top;    // Return address on the stack
  logic   push;
  logic   pop;
  logic   empty;
  logic   full;

  assign ma_inc = ma + 1'b1;  // Wraps at the top of the control store

  // Next address select
  always_comb begin
    ma_d = ma_inc;
    push = 1'b0;
    pop  = 1'b0;
    case (seq_op)
      SEQ_JUMP: begin
        if (c.taken)
          ma_d = target;
      end
      SEQ_CALL: begin
        if (c.taken) begin
          ma_d = target;
          push = step;  // Saves ma+1
        end
      end
      SEQ_RET: begin
        // Return on an empty stack falls through
        if (c.taken && !empty) begin
          ma_d = top;
          pop  = step;
        end
      end
      default: ma_d = ma_inc;
    endcase
  end

  always_ff @(posedge sysclk) begin
    if (!rst_n)
      ma <= '0;
    else if (step)
      ma <= ma_d;
  end

  mic_stack #(
    .STACK_DEPTH(STACK_DEPTH)
  ) u_stack (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .push     (push),
    .pop      (pop),
    .push_data(ma_inc),
    .top      (top),
    .empty    (empty),
    .full     (full)
  );

  assign deep = full;

endmodule

/* logic/mic_top.sv */
`timescale 1ns/100ps

module mic_top #(
  parameter int STACK_DEPTH = mic_cfg_pkg::STACK_DEPTH,
  parameter int LC_W        = mic_cfg_pkg::LC_W
) (
  input  logic                sysclk,
  input  logic                rst_n,
  input  logic                step,     // One microcycle per high clock edge
  input  logic                cond_en,
  input  logic                tpol,
  input  logic                csloop,
  input  logic                ldlc,
  input  logic                ldir,
  input  mic_cfg_pkg::data_t  cd,
  input  mic_cfg_pkg::csbit_t csbit,
  input  mic_cfg_pkg::flags_t flags,
  input  logic [2:0]          tsel,
  input  mic_cfg_pkg::raddr_t pil,
  input  mic_op_pkg::seq_op_t seq_op,
  input  mic_op_pkg::jsel_t   jsel,
  input  mic_op_pkg::asel_t   asel,
  input  mic_op_pkg::bsel_t   bsel,
  output mic_cfg_pkg::uaddr_t ma,
  output mic_cfg_pkg::raddr_t laa,
  output mic_cfg_pkg::raddr_t lba,
  output logic                cond,
  output logic                lcz_n,
  output logic                deep
);
  import mic_cfg_pkg::*;

  uaddr_t target;  // Decode to address select

  cond_if c ();

  // Condition unit and decode unit run side by side
  mic_cond #(
    .LC_W(LC_W)
  ) u_cond (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .step   (step),
    .flags  (flags),
    .tsel   (tsel),
    .tpol   (tpol),
    .cond_en(cond_en),
    .csloop (csloop),
    .ldlc   (ldlc),
    .cd     (cd),
    .c      (c)
  );

  mic_decode u_decode (
    .sysclk(sysclk),
    .rst_n (rst_n),
    .step  (step),
    .ldir  (ldir),
    .cd    (cd),
    .csbit (csbit),
    .pil   (pil),
    .asel  (asel),
    .bsel  (bsel),
    .jsel  (jsel),
    .c     (c),
    .laa   (laa),
    .lba   (lba),
    .target(target)
  );

  mic_masel #(
    .STACK_DEPTH(STACK_DEPTH)
  ) u_masel (
    .sysclk(sysclk),
    .rst_n (rst_n),
    .step  (step),
    .seq_op(seq_op),
    .target(target),
    .c     (c),
    .ma    (ma),
    .deep  (deep)
  );

  assign cond  = c.cond_q;
  assign lcz_n = ~c.lcz;  // Active low at the pins

endmodule

/* tb/mic_model.svh */
`ifndef MIC_MODEL_SVH
`define MIC_MODEL_SVH

// Reference copy of the sequencer registers
uaddr_t m_ma;
lc_t    m_lc;
ir_t    m_ir;
raddr_t m_laa;
raddr_t m_lba;
logic   m_cond;
uaddr_t m_stack[$];  // Front holds the latest return address

task automatic model_reset();
  m_ma   = '0;
  m_lc   = '0;
  m_ir   = '0;
  m_laa  = '0;
  m_lba  = '0;
  m_cond = 1'b0;
  m_stack.delete();
endtask

// One microcycle with the inputs currently on the DUT pins
task automatic model_step();
  logic   ok;
  uaddr_t tgt;
  uaddr_t inc;
  raddr_t a_nx;
  raddr_t b_nx;
  if (csloop)
    ok = (m_lc != 0);
  else if (!cond_en)
    ok = 1'b1;
  else
    ok = flags[tsel] ^ tpol;
  case (jsel)
    JMP_VEC: tgt = {csbit[UADDR_W-1:4], m_ir[3:0]};
    JMP_REG: tgt = {csbit[UADDR_W-1:4], m_laa};
    default: tgt = csbit[UADDR_W-1:0];
  endcase
  case (asel)
    ASEL_LIT: a_nx = csbit[15:12];
    ASEL_PIL: a_nx = pil;
    ASEL_IR:  a_nx = m_ir[6:3];
    default:  a_nx = m_lc[3:0];
  endcase
  case (bsel)
    BSEL_LIT:  b_nx = csbit[11:8];
    BSEL_IRLO: b_nx = {1'b0, m_ir[2:0]};
    BSEL_IRHI: b_nx = {1'b0, m_ir[5:3]};
    default:   b_nx = m_lc[3:0];
  endcase
  inc = m_ma + 1;  // Wraps at 2^13
  m_ma = inc;
  if (seq_op == SEQ_JUMP && ok)
    m_ma = tgt;
  if (seq_op == SEQ_CALL && ok) begin
    m_stack.push_front(inc);
    if (m_stack.size() > STACK_DEPTH)
      void'(m_stack.pop_back());  // Oldest entry lost
    m_ma = tgt;
  end
  if (seq_op == SEQ_RET && ok && m_stack.size() != 0)
    m_ma = m_stack.pop_front();
  if (ldlc)
    m_lc = cd[LC_W-1:0];
  else if (csloop && m_lc != 0)
    m_lc = m_lc - 1;
  if (ldir)
    m_ir = cd[IR_W-1:0];
  m_laa  = a_nx;
  m_lba  = b_nx;
  m_cond = ok;
endtask

`endif

/* tb/mic_tb.sv */
`timescale 1ns/100ps

module mic_tb;
  import mic_cfg_pkg::*;
  import mic_op_pkg::*;

  localparam int LOOPS = 6;
  localparam int TIMEOUT_CYCLES = 8 + 40 + 400 + LOOPS * 16
                                + 3 * (2 * STACK_DEPTH + 5) + 150 + 200 + 600 + 500;

  logic    sysclk;
  logic    rst_n;
  logic    step;
  logic    cond_en;
  logic    tpol;
  logic    csloop;
  logic    ldlc;
  logic    ldir;
  data_t   cd;
  csbit_t  csbit;
  flags_t  flags;
  logic [2:0] tsel;
  raddr_t  pil;
  seq_op_t seq_op;
  jsel_t   jsel;
  asel_t   asel;
  bsel_t   bsel;
  uaddr_t  ma;
  raddr_t  laa;
  raddr_t  lba;
  logic    cond;
  logic    lcz_n;
  logic    deep;

  integer seed = 64375;
  int     cycles = 0;
  int     checks = 0;
  int     errors = 0;
  int     err_start = 0;
  int     tests_run = 0;

  `include "mic_model.svh"

  mic_top uut (.*);

  initial begin
    sysclk = 1'b0;
    forever #50 sysclk = ~sysclk;
  end

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycles);
    end
  endtask

  task automatic check_outputs();
    check_value("ma", 16'(ma), 16'(m_ma));
    check_value("laa", 16'(laa), 16'(m_laa));
    check_value("lba", 16'(lba), 16'(m_lba));
    check_value("cond", 16'(cond), 16'(m_cond));
    check_value("lcz_n", 16'(lcz_n), 16'(m_lc != 0));
    check_value("deep", 16'(deep), 16'(m_stack.size() == STACK_DEPTH));
  endtask

  task automatic randomize_inputs();
    step    = 1'b1;
    cond_en = 1'(rand32());
    tpol    = 1'(rand32());
    csloop  = 1'(rand32());
    ldlc    = 1'(rand32());
    ldir    = 1'(rand32());
    cd      = data_t'(rand32());
    csbit   = csbit_t'(rand32());
    flags   = flags_t'(rand32());
    tsel    = 3'(rand32());
    pil     = raddr_t'(rand32());
    seq_op  = seq_op_t'(2'(rand32()));
    jsel    = jsel_t'(2'(rand32() % 3));  // Only three target sources
    asel    = asel_t'(2'(rand32()));
    bsel    = bsel_t'(2'(rand32()));
  endtask

  // Inputs are already set on a falling edge
  task automatic run_cycle();
    if (step)
      model_step();
    @(negedge sysclk);
    check_outputs();
  endtask

  task automatic stack_step(input seq_op_t op, input logic force_taken);
    randomize_inputs();
    csloop = 1'b0;
    if (force_taken)
      cond_en = 1'b0;
    seq_op = op;
    run_cycle();
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("Test %-14s done, %0d mismatches", name, errors - err_start);
    err_start = errors;
  endtask

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge sysclk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    randomize_inputs();
    step = 1'b0;
    repeat (8) @(posedge sysclk);
    @(negedge sysclk);
    rst_n = 1'b1;
    model_reset();
    check_outputs();  // Reset values

    repeat (40) begin
      randomize_inputs();
      step = 1'b0;
      run_cycle();
    end
    finish_test("reset_hold");

    repeat (400) begin
      randomize_inputs();
      csloop = 1'b0;
      seq_op = rand32() % 2 ? SEQ_JUMP : SEQ_NEXT;
      run_cycle();
    end
    finish_test("cond_jump");

    repeat (LOOPS) begin
      randomize_inputs();
      csloop = 1'b0;
      ldlc   = 1'b1;
      cd     = data_t'(1 + rand32() % 12);
      seq_op = SEQ_NEXT;
      run_cycle();
      // Runs down to zero, then one more step for the exit
      do begin
        randomize_inputs();
        csloop = 1'b1;
        ldlc   = 1'b0;
        seq_op = SEQ_JUMP;
        run_cycle();
      end while (m_cond);
    end
    finish_test("loop_count");

    repeat (3) begin
      repeat (STACK_DEPTH + 2) stack_step(SEQ_CALL, 1'b1);
      repeat (STACK_DEPTH + 3) stack_step(SEQ_RET, 1'b1);  // Last ones hit an empty stack
    end
    repeat (150) stack_step(rand32() % 2 ? SEQ_CALL : SEQ_RET, 1'(rand32() % 4 != 0));
    finish_test("call_return");

    repeat (200) begin
      randomize_inputs();
      csloop  = 1'b0;
      cond_en = 1'b0;
      seq_op  = SEQ_JUMP;
      run_cycle();
    end
    finish_test("reg_target");

    repeat (600) begin
      randomize_inputs();
      step = 1'(rand32());
      run_cycle();
    end
    finish_test("mixed");

    $display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* list.f */
+incdir+tb
logic/mic_cfg_pkg.sv
logic/mic_op_pkg.sv
logic/mic_if.sv
logic/mic_cond.sv
logic/mic_decode.sv
logic/mic_stack.sv
logic/mic_masel.sv
logic/mic_top.sv
tb/mic_tb.sv
